// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_i2s_pwm
FLIST    := i2s_pwm.f
OBJDIR   := obj_dir
LOG      := sim.log
FAIL_MSG := TEST FAILED

SHELL    := /bin/bash

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: compile
	set -o pipefail; ./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       bclk,
    input  i2s_pwm_pkg::pcm_sample_t   sample,
    input  logic                       left_valid,
    input  logic                       right_valid,
    input  logic                       pwm_left,
    input  logic                       pwm_right,
    input  i2s_pwm_pkg::frame_status_t status,
    output int                         errors
);

    import i2s_pwm_pkg::*;

    // 32-bit slots, bclk of 16 clk
    localparam int SLOT_BITS  = 32;
    localparam int FRAME_CLKS = 2 * SLOT_BITS * 16;
    localparam int PERIOD     = 1 << PWM_W;

    logic [31:0] left_q[$];
    logic [31:0] right_q[$];
    int          word_errs;
    int          pwm_errs;
    int          status_errs;
    int          other_errs;
    int          cyc;
    logic        bclk_seen;
    // Per channel, index 0 left and 1 right
    int          strobes[2];
    logic [23:0] new_w[2];
    logic [23:0] prev_w[2];
    logic        prev_pwm[2];
    int          hi_len[2];
    int          rise_at[2];
    int          last_rise[2];
    int          last_len[2];
    int          pulses[2];

    assign errors = word_errs + pwm_errs + status_errs + other_errs;

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Word is the first SAMPLE_W bits of an MSB-first slot
    function automatic logic [23:0] word_of(input logic [31:0] slot);
        return slot[31 -: SAMPLE_W];
    endfunction

    // Signed top byte moved up by half scale
    function automatic int duty_of(input logic [23:0] w);
        int top;
        top = int'($signed(w[SAMPLE_W-1 -: PWM_W]));
        return top + (1 << (PWM_W - 1));
    endfunction

    task automatic push_pair(input logic [31:0] l_slot, input logic [31:0] r_slot);
        left_q.push_back(l_slot);
        right_q.push_back(r_slot);
    endtask

    function automatic int words_left();
        return left_q.size() + right_q.size();
    endfunction

    task automatic mismatch(input string name, input int exp, input int act);
        $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, exp, act);
    endtask

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_quiet(input string name, input int act);
        if (act != 0) begin
            mismatch(name, 0, act);
            other_errs++;
        end
    endtask

    task automatic check_word(input int ch);
        logic [31:0] slot;
        logic [23:0] exp_w;
        string       name;
        name = (ch == 0) ? "sample on left_valid" : "sample on right_valid";
        if ((ch == 0 && left_q.size() == 0) || (ch == 1 && right_q.size() == 0)) begin
            $display("Error at time %0t: strobe for a word that was never sent (%s)",
                     $time, name);
            other_errs++;
        end else begin
            slot  = (ch == 0) ? left_q.pop_front() : right_q.pop_front();
            exp_w = word_of(slot);
            if (sample !== exp_w) begin
                mismatch(name, int'({8'h00, exp_w}), int'({8'h00, sample}));
                word_errs++;
            end
            prev_w[ch] = new_w[ch];
            new_w[ch]  = exp_w;
            // From frame 2 on, status holds full-frame numbers
            if (strobes[ch] >= 2) begin
                if (int'(status.slot_bits) != SLOT_BITS) begin
                    mismatch("status.slot_bits", SLOT_BITS, int'(status.slot_bits));
                    status_errs++;
                end
                if (int'(status.frame_clks) != FRAME_CLKS) begin
                    mismatch("status.frame_clks", FRAME_CLKS, int'(status.frame_clks));
                    status_errs++;
                end
            end
            strobes[ch]++;
        end
    endtask

    task automatic track_pwm(input int ch, input logic p);
        int d_new;
        int d_old;
        d_new = duty_of(new_w[ch]);
        d_old = duty_of(prev_w[ch]);
        if (p) begin
            if (!prev_pwm[ch]) begin
                rise_at[ch] = cyc;
            end
            hi_len[ch]++;
        end else if (prev_pwm[ch]) begin
            // Pulse over, either duty may be active
            if (hi_len[ch] != d_new && hi_len[ch] != d_old) begin
                mismatch((ch == 0) ? "pwm_left high time" : "pwm_right high time",
                         d_new, hi_len[ch]);
                pwm_errs++;
            end
            // Steady duty, so one pulse per period
            if (d_new == d_old && d_new != 0 && hi_len[ch] == d_new &&
                last_len[ch] == hi_len[ch] && rise_at[ch] - last_rise[ch] != PERIOD) begin
                mismatch((ch == 0) ? "pwm_left period" : "pwm_right period",
                         PERIOD, rise_at[ch] - last_rise[ch]);
                pwm_errs++;
            end
            last_len[ch]  = hi_len[ch];
            last_rise[ch] = rise_at[ch];
            hi_len[ch]    = 0;
            pulses[ch]++;
        end
        prev_pwm[ch] = p;
    endtask

    //////////////////////////////////////////////////
    // Monitor, sampled mid cycle
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!arst_n) begin
            word_errs   = 0;
            pwm_errs    = 0;
            status_errs = 0;
            other_errs  = 0;
            cyc         = 0;
            bclk_seen   = 1'b0;
            for (int ch = 0; ch < 2; ch++) begin
                strobes[ch]   = 0;
                new_w[ch]     = '0;
                prev_w[ch]    = '0;
                prev_pwm[ch]  = 1'b0;
                hi_len[ch]    = 0;
                rise_at[ch]   = 0;
                last_rise[ch] = 0;
                last_len[ch]  = 0;
                pulses[ch]    = 0;
            end
        end else begin
            cyc++;
            if (bclk) begin
                bclk_seen = 1'b1;
            end
            // Nothing may move before the first frame
            if (!bclk_seen) begin
                check_quiet("left_valid", int'(left_valid));
                check_quiet("right_valid", int'(right_valid));
                check_quiet("pwm_left", int'(pwm_left));
                check_quiet("pwm_right", int'(pwm_right));
                check_quiet("status.slot_bits", int'(status.slot_bits));
                check_quiet("status.frame_clks", int'(status.frame_clks));
            end
            if (left_valid && right_valid) begin
                $display("Error at time %0t: left_valid and right_valid high together", $time);
                other_errs++;
            end
            if (left_valid) begin
                check_word(0);
            end
            if (right_valid) begin
                check_word(1);
            end
            track_pwm(0, pwm_left);
            track_pwm(1, pwm_right);
        end
    end

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    // 4 ns period
    localparam real HALF_NS = 2.0;

    initial begin
        clk = 1'b0;
    end

    always begin
        #(HALF_NS) clk = ~clk;
    end

endmodule

// ==== dv/tb_i2s_pwm.sv ====
`timescale 1ns/1ps

module tb_i2s_pwm;

    import i2s_pwm_pkg::*;

    localparam int N_FIXED     = 3;
    localparam int N_RAND      = 4;
    localparam int N_PAIRS     = N_FIXED + N_RAND;
    // Each pair goes out in two frames
    localparam int N_FRAMES    = 2 * N_PAIRS;
    localparam int BCLK_HALF   = 8;
    localparam int SLOT_LEN    = 32;
    localparam int WATCHDOG_NS = N_FRAMES * 1024 * 4 + 2000;

    logic          clk;
    logic          arst_n;
    logic          bclk;
    logic          lrclk;
    logic          sdata;
    logic          pwm_left;
    logic          pwm_right;
    pcm_sample_t   sample;
    logic          left_valid;
    logic          right_valid;
    frame_status_t status;
    int            errors;
    int            end_errs;
    logic [15:0]   lfsr;
    logic [23:0]   left_w[N_PAIRS];
    logic [23:0]   right_w[N_PAIRS];

    tb_clk_gen clk0 (.clk(clk));

    i2s_pwm_top dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .bclk        (bclk),
        .lrclk       (lrclk),
        .sdata       (sdata),
        .pwm_left    (pwm_left),
        .pwm_right   (pwm_right),
        .sample      (sample),
        .left_valid  (left_valid),
        .right_valid (right_valid),
        .status      (status)
    );

    tb_checker chk0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .bclk        (bclk),
        .sample      (sample),
        .left_valid  (left_valid),
        .right_valid (right_valid),
        .pwm_left    (pwm_left),
        .pwm_right   (pwm_right),
        .status      (status),
        .errors      (errors)
    );

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    // One LFSR step per bit
    task automatic random_word(output logic [23:0] w);
        for (int i = 0; i < 24; i++) begin
            w    = {w[22:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // One bclk period, entered 1 ns after a rising clk
    // Data and word select change on the falling bclk
    task automatic bclk_cycle(input logic lr, input logic d);
        bclk  = 1'b0;
        lrclk = lr;
        sdata = d;
        repeat (BCLK_HALF) @(posedge clk);
        #1;
        bclk = 1'b1;
        repeat (BCLK_HALF) @(posedge clk);
        #1;
    endtask

    // Standard I2S, data one bclk behind the lrclk change
    task automatic send_frame(input logic [31:0] l_slot, input logic [31:0] r_slot);
        logic [63:0] stream;
        stream = {l_slot, r_slot};
        for (int k = 0; k < 2 * SLOT_LEN; k++) begin
            // k = 0 carries the LSB of the last right slot, always padding
            bclk_cycle(k >= SLOT_LEN, (k == 0) ? 1'b0 : stream[2 * SLOT_LEN - k]);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        arst_n   = 1'b0;
        bclk     = 1'b0;
        lrclk    = 1'b0;
        sdata    = 1'b0;
        lfsr     = 16'd4988;
        end_errs = 0;
        // Full scale negative, full scale positive and silence
        left_w[0]  = 24'h800000;
        right_w[0] = 24'h7fffff;
        left_w[1]  = 24'h000000;
        right_w[1] = 24'h000000;
        left_w[2]  = 24'h7fffff;
        right_w[2] = 24'h800000;
        for (int p = N_FIXED; p < N_PAIRS; p++) begin
            random_word(left_w[p]);
            random_word(right_w[p]);
        end

        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // Quiet gap before the first frame
        repeat (20) @(posedge clk);
        #1;

        for (int p = 0; p < N_PAIRS; p++) begin
            for (int f = 0; f < 2; f++) begin
                chk0.push_pair({left_w[p], 8'h00}, {right_w[p], 8'h00});
                send_frame({left_w[p], 8'h00}, {right_w[p], 8'h00});
            end
        end
        // Closes the last right slot
        bclk_cycle(1'b0, 1'b0);

        while (chk0.words_left() != 0) begin
            @(posedge clk);
        end
        // Let the last PWM period run out
        repeat (260) @(posedge clk);

        if (chk0.words_left() != 0) begin
            $display("Error: some words sent were never received");
            end_errs++;
        end
        if (chk0.pulses[0] == 0 || chk0.pulses[1] == 0) begin
            $display("Error: no PWM pulse seen on at least one channel");
            end_errs++;
        end
        $display("Errors: words %0d, pwm %0d, status %0d, other %0d, end of run %0d",
                 chk0.word_errs, chk0.pwm_errs, chk0.status_errs, chk0.other_errs, end_errs);
        if (errors + end_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Run time bound from the frame count
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== i2s_pwm.f ====
rtl/i2s_pwm_pkg.sv
rtl/i2s_rx.sv
rtl/pcm_pwm_mod.sv
rtl/i2s_pwm_top.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/tb_i2s_pwm.sv

// ==== rtl/i2s_pwm_pkg.sv ====
package i2s_pwm_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // Audio word kept from each I2S slot
    localparam int SAMPLE_W = 24;

    // PWM counter resolution, period is 2**PWM_W clocks
    localparam int PWM_W = 8;

    // Bit counter inside one slot
    // Wide enough for slots up to 255 bclk edges
    localparam int SLOT_CNT_W = 8;

    // System clocks per stereo frame
    localparam int FRAME_CNT_W = 12;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    // Two's complement audio sample, MSB first on the wire
    typedef logic signed [SAMPLE_W-1:0] pcm_sample_t;

    // Frame measurements reported to the host
    typedef struct packed {
        // bclk edges in the last completed slot
        logic [SLOT_CNT_W-1:0]  slot_bits;
        // clk cycles between two left-slot starts
        logic [FRAME_CNT_W-1:0] frame_clks;
    } frame_status_t;

endpackage

// ==== rtl/i2s_pwm_top.sv ====
`timescale 1ns/1ps

module i2s_pwm_top (
    input  logic                       clk,
    input  logic                       arst_n,
    // I2S slave lines from the external master
    input  logic                       bclk,
    input  logic                       lrclk,
    input  logic                       sdata,
    // Class-D drive, one per channel
    output logic                       pwm_left,
    output logic                       pwm_right,
    // Received words and status for the host
    output i2s_pwm_pkg::pcm_sample_t   sample,
    output logic                       left_valid,
    output logic                       right_valid,
    output i2s_pwm_pkg::frame_status_t status
);

    //////////////////////////////////////////////////
    // I2S receiver
    //////////////////////////////////////////////////

    // Runs on clk, oversamples the I2S lines
    i2s_rx rx0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .bclk        (bclk),
        .lrclk       (lrclk),
        .sdata       (sdata),
        .sample      (sample),
        .left_valid  (left_valid),
        .right_valid (right_valid),
        .status      (status)
    );

    //////////////////////////////////////////////////
    // Per-channel modulators
    //////////////////////////////////////////////////

    // Both share the word bus, each loads on its own strobe
    pcm_pwm_mod mod_left (
        .clk    (clk),
        .arst_n (arst_n),
        .sample (sample),
        .load   (left_valid),
        .pwm    (pwm_left)
    );

    pcm_pwm_mod mod_right (
        .clk    (clk),
        .arst_n (arst_n),
        .sample (sample),
        .load   (right_valid),
        .pwm    (pwm_right)
    );

endmodule

// ==== rtl/i2s_rx.sv ====
`timescale 1ns/1ps

module i2s_rx (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       bclk,
    input  logic                       lrclk,
    input  logic                       sdata,
    output i2s_pwm_pkg::pcm_sample_t   sample,
    output logic                       left_valid,
    output logic                       right_valid,
    output i2s_pwm_pkg::frame_status_t status
);

    import i2s_pwm_pkg::*;

    // The three external lines, kept together through the sync chain
    typedef struct packed {
        logic bclk;
        logic lrclk;
        logic sdata;
    } i2s_lines_t;

    i2s_lines_t               meta_q;
    i2s_lines_t               sync_q;
    i2s_lines_t               line_q;
    logic                     bclk_rise;
    logic                     lr_prev;
    logic                     lr_change;
    logic                     take_bit;
    logic                     word_done;
    logic [SLOT_CNT_W-1:0]    bit_cnt;
    logic [FRAME_CNT_W-1:0]   clk_cnt;
    logic [SAMPLE_W-1:0]      shift_q;

    //////////////////////////////////////////////////
    // Line synchronizers and bclk edge detect
    //////////////////////////////////////////////////

    // Two flops against metastability, then one more stage so that
    // lrclk and sdata line up with the registered edge pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            meta_q    <= '0;
            sync_q    <= '0;
            line_q    <= '0;
            bclk_rise <= 1'b0;
        end else begin
            meta_q    <= '{bclk: bclk, lrclk: lrclk, sdata: sdata};
            sync_q    <= meta_q;
            line_q    <= sync_q;
            // Pin edge shows here 3 clk later
            bclk_rise <= sync_q.bclk & ~line_q.bclk;
        end
    end

    //////////////////////////////////////////////////
    // Slot tracking
    //////////////////////////////////////////////////

    // Word select sampled on the same bclk edge as the data
    assign lr_change = bclk_rise && (line_q.lrclk != lr_prev);

    // Edge with the lrclk change carries the last bit of the old slot,
    // so bit_cnt holds the bit index of the current edge
    // Bit 1 is the MSB
    assign take_bit  = bclk_rise && !lr_change &&
                       (bit_cnt >= SLOT_CNT_W'(1)) &&
                       (bit_cnt <= SLOT_CNT_W'(SAMPLE_W));

    // Last kept bit of the word
    assign word_done = bclk_rise && !lr_change &&
                       (bit_cnt == SLOT_CNT_W'(SAMPLE_W));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lr_prev     <= 1'b0;
            bit_cnt     <= '0;
            clk_cnt     <= '0;
            status      <= '0;
            left_valid  <= 1'b0;
            right_valid <= 1'b0;
        end else begin
            // Strobe 1 clk after the seen edge
            left_valid  <= word_done && !line_q.lrclk;
            right_valid <= word_done && line_q.lrclk;

            clk_cnt <= clk_cnt + 1'b1;

            if (lr_change) begin
                lr_prev          <= line_q.lrclk;
                status.slot_bits <= bit_cnt;
                // Change edge is the first edge of the new slot
                bit_cnt          <= SLOT_CNT_W'(1);
                // Left slot start closes the frame
                if (!line_q.lrclk) begin
                    status.frame_clks <= clk_cnt;
                    // Current cycle counts as the first one
                    clk_cnt           <= FRAME_CNT_W'(1);
                end
            end else if (bclk_rise) begin
                // Hold at full scale on very long slots
                if (bit_cnt != '1) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////

    // MSB first, bits beyond SAMPLE_W are dropped
    always_ff @(posedge clk) begin
        if (take_bit) begin
            shift_q <= {shift_q[SAMPLE_W-2:0], line_q.sdata};
        end
        // Complete word goes out together with the strobe
        if (word_done) begin
            sample <= {shift_q[SAMPLE_W-2:0], line_q.sdata};
        end
    end

    // Strobe channel matches the word select of the current slot
    // Never both at once
    a_strobe_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(left_valid && right_valid) &&
        !(left_valid && lr_prev) &&
        !(right_valid && !lr_prev)
    );

    // Each strobe follows a low to high step of the synced bclk line
    a_strobe_after_edge: assert property (
        @(posedge clk) disable iff (!arst_n)
        (left_valid || right_valid) |-> ($past(line_q.bclk) && !$past(line_q.bclk, 2))
    );

endmodule

// ==== rtl/pcm_pwm_mod.sv ====
`timescale 1ns/1ps

module pcm_pwm_mod (
    input  logic                     clk,
    input  logic                     arst_n,
    input  i2s_pwm_pkg::pcm_sample_t sample,
    input  logic                     load,
    output logic                     pwm
);

    import i2s_pwm_pkg::*;

    logic [PWM_W-1:0] cnt;
    logic [PWM_W-1:0] duty_new;
    logic [PWM_W-1:0] duty_pend;
    logic [PWM_W-1:0] duty_act;
    logic             pend_vld;
    logic             run_q;
    logic             wrap;

    //////////////////////////////////////////////////
    // Sample to duty
    //////////////////////////////////////////////////

    // Top PWM_W bits with the sign flipped, i.e. offset binary
    // Zero maps to mid scale
    function automatic logic [PWM_W-1:0] to_duty(input pcm_sample_t s);
        logic [PWM_W-1:0] d;
        d = {~s[SAMPLE_W-1], s[SAMPLE_W-2 -: PWM_W-1]};
        return d;
    endfunction

    assign duty_new = to_duty(sample);

    //////////////////////////////////////////////////
    // Period counter
    //////////////////////////////////////////////////

    // Free running, wraps every 2**PWM_W clocks
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Last count of the period, next cycle starts a new one
    assign wrap = (cnt == '1);

    //////////////////////////////////////////////////
    // Pending and active duty
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Mid scale until the first word arrives
            duty_pend <= {1'b1, {(PWM_W-1){1'b0}}};
            duty_act  <= {1'b1, {(PWM_W-1){1'b0}}};
            pend_vld  <= 1'b0;
            run_q     <= 1'b0;
        end else begin
            // Newest sample wins, older one is simply overwritten
            if (load) begin
                duty_pend <= duty_new;
                pend_vld  <= 1'b1;
            end

            // Period start takes over the pending duty
            if (wrap) begin
                // Word loaded in the last cycle still makes this period
                duty_act <= load ? duty_new : duty_pend;
                run_q    <= pend_vld | load;
            end
        end
    end

    //////////////////////////////////////////////////
    // Output compare
    //////////////////////////////////////////////////

    // High while the counter is below the duty
    // Output stays low until a first word has reached a period start
    assign pwm = run_q && (cnt < duty_act);

    // Duty is only swapped at the period boundary, so no pulse is cut short
    a_duty_at_wrap: assert property (
        @(posedge clk) disable iff (!arst_n)
        (duty_act != $past(duty_act)) |-> (cnt == '0)
    );

endmodule
